/* rtl/bus_pkg.sv */
/*
 * Pin bus definitions: the transaction the core hands to the bus
 * handler, and the numbering of the ten clock phases of one frame.
 */

`default_nettype none

package bus_pkg;

  // one complete transaction, carried by one frame
  typedef struct packed {
    logic [31:0] addr;
    logic [31:0] wdata;
    logic        write;
  } bus_req_t;

  typedef logic [3:0] bus_phase_t; // 0 to 9

  localparam bus_phase_t PH_STEP       = 4'd0; // core steps here
  localparam bus_phase_t PH_ADDR_FIRST = 4'd1; // address LSB first
  localparam bus_phase_t PH_ADDR_LAST  = 4'd4;
  localparam bus_phase_t PH_FLAG       = 4'd5; // write flag on bit 0
  localparam bus_phase_t PH_READ_FIRST = 4'd6; // read data MSB first
  localparam bus_phase_t PH_READ_LAST  = 4'd9;

  localparam int FRAME_LEN = 10; // clocks per frame

  function automatic bus_req_t read_req(logic [31:0] addr);
    return '{addr: addr, wdata: 32'h0, write: 1'b0};
  endfunction

  function automatic bus_req_t write_req(logic [31:0] addr, logic [31:0] wdata);
    return '{addr: addr, wdata: wdata, write: 1'b1};
  endfunction

endpackage

`default_nettype wire

/* rtl/cpu_pkg.sv */
/*
 * Accumulator processor definitions: opcodes, the instruction
 * word layout and the ALU operation codes.
 */

`default_nettype none

package cpu_pkg;

  // codes 11 to 15 are unused and act as no-operation
  typedef enum logic [3:0] {
    OP_LDI  = 4'd0,
    OP_LD   = 4'd1,
    OP_ST   = 4'd2,
    OP_ADD  = 4'd3,
    OP_SUB  = 4'd4,
    OP_AND  = 4'd5,
    OP_OR   = 4'd6,
    OP_XOR  = 4'd7,
    OP_JMP  = 4'd8,
    OP_JZ   = 4'd9,
    OP_HALT = 4'd10
  } opcode_t;

  typedef struct packed {
    opcode_t     op;
    logic [27:0] operand; // immediate or byte address
  } instr_t;

  typedef enum logic [2:0] {
    ALU_PASS = 3'd0, // result is b
    ALU_ADD  = 3'd1,
    ALU_SUB  = 3'd2, // a - b
    ALU_AND  = 3'd3,
    ALU_OR   = 3'd4,
    ALU_XOR  = 3'd5
  } alu_op_t;

  // operand widened to a full data word
  function automatic logic [31:0] operand_value(instr_t instr);
    return {4'h0, instr.operand};
  endfunction

  // ALU operation used in the execute step of a memory opcode
  function automatic alu_op_t alu_op_of(opcode_t op);
    case (op)
      OP_ADD:  return ALU_ADD;
      OP_SUB:  return ALU_SUB;
      OP_AND:  return ALU_AND;
      OP_OR:   return ALU_OR;
      OP_XOR:  return ALU_XOR;
      default: return ALU_PASS; // LD and the rest
    endcase
  endfunction

endpackage

`default_nettype wire

/* rtl/cpu_alu.sv */
/*
 * Accumulator ALU. Purely combinational; wrapping add and
 * subtract, bitwise logic, pass-through of b, and a zero flag.
 */

`default_nettype none

module cpu_alu
  import cpu_pkg::*;
(
  input  logic [31:0] a,
  input  logic [31:0] b,
  input  alu_op_t     op,
  output logic [31:0] res,
  output logic        zero
);

  always_comb begin
    case (op)
      ALU_PASS: begin
        res = b;
      end
      ALU_ADD: begin
        res = a + b; // wraps at 32 bits
      end
      ALU_SUB: begin
        res = a - b;
      end
      ALU_AND: begin
        res = a & b;
      end
      ALU_OR: begin
        res = a | b;
      end
      ALU_XOR: begin
        res = a ^ b;
      end
      default: begin
        res = b; // unused codes behave like pass
      end
    endcase
  end

  // the core reads this in fetch for JZ
  assign zero = (res == 32'h0);

endmodule

`default_nettype wire

/* rtl/accum_cpu.sv */
/*
 * Two-state accumulator core. Steps once per bus frame: a fetch
 * step decodes the word just read, an execute step finishes a
 * memory operation. Each step registers the request for the next
 * frame.
 */

`default_nettype none

module accum_cpu
  import bus_pkg::*;
  import cpu_pkg::*;
#(
  parameter logic [31:0] RESET_PC = 32'h0
) (
  input  logic        clk,
  input  logic        arst_n,
  input  logic        step,
  input  logic [31:0] rdata,
  input  logic [31:0] alu_res,
  input  logic        alu_zero,
  output bus_req_t    req,
  output logic [31:0] alu_a,
  output logic [31:0] alu_b,
  output alu_op_t     alu_op
);

  typedef enum logic {
    FETCH,
    EXEC
  } state_t;

  state_t      state;
  logic        halted;
  logic [31:0] acc;
  logic [31:0] pc;
  instr_t      ir;      // instruction waiting for its operand
  instr_t      fetched;
  logic [31:0] opnd;
  logic [31:0] pc_inc;

  assign fetched = instr_t'(rdata);
  assign opnd    = operand_value(fetched);
  assign pc_inc  = pc + 32'd4;

  // in fetch the ALU passes acc through, so alu_zero tests acc for JZ
  assign alu_a  = acc;
  assign alu_b  = (state == EXEC) ? rdata : acc;
  assign alu_op = (state == EXEC) ? alu_op_of(ir.op) : ALU_PASS;

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      state  <= FETCH;
      halted <= 1'b0;
      acc    <= 32'h0;
      pc     <= RESET_PC;
      ir     <= '0;
      req    <= read_req(RESET_PC); // first frame fetches at once
    end else if (step && !halted) begin
      if (state == FETCH) begin
        case (fetched.op)
          OP_LDI: begin
            acc <= opnd;
            pc  <= pc_inc;
            req <= read_req(pc_inc);
          end
          OP_LD, OP_ADD, OP_SUB, OP_AND, OP_OR, OP_XOR: begin
            ir    <= fetched;
            state <= EXEC;
            req   <= read_req(opnd); // operand word arrives next step
          end
          OP_ST: begin
            ir    <= fetched;
            state <= EXEC;
            req   <= write_req(opnd, acc);
          end
          OP_JMP: begin
            pc  <= opnd;
            req <= read_req(opnd);
          end
          OP_JZ: begin
            if (alu_zero) begin
              pc  <= opnd;
              req <= read_req(opnd);
            end else begin
              pc  <= pc_inc;
              req <= read_req(pc_inc);
            end
          end
          OP_HALT: begin
            halted <= 1'b1;
            req    <= read_req(pc); // same fetch repeats from here on
          end
          default: begin
            pc  <= pc_inc; // no-operation
            req <= read_req(pc_inc);
          end
        endcase
      end else begin
        if (ir.op != OP_ST) begin
          acc <= alu_res;
        end
        pc    <= pc_inc;
        state <= FETCH;
        req   <= read_req(pc_inc);
      end
    end
  end

endmodule

`default_nettype wire

/* rtl/bus_phase_handler.sv */
/*
 * Pin bus handler. Runs the ten-phase frame: address bytes out,
 * write flag, four read bytes in, then a one-clock step strobe
 * for the core.
 */

`default_nettype none

module bus_phase_handler
  import bus_pkg::*;
(
  input  logic        clk,
  input  logic        arst_n,
  input  bus_req_t    req,
  input  logic [7:0]  uio_in,
  output logic        step,
  output logic [31:0] rdata,
  output logic [7:0]  uo_out,
  output logic [7:0]  uio_out,
  output logic [7:0]  uio_oe
);

  bus_phase_t       phase;
  logic [3:0][7:0]  rd_q;     // gathered read word
  logic [3:0][7:0]  addr_b;
  logic [3:0][7:0]  wdata_b;
  logic             in_addr;
  logic             in_read;
  logic [1:0]       out_sel;  // byte on the pins in phases 1-4
  logic [1:0]       rd_sel;   // byte filled in phases 6-9

  assign addr_b  = req.addr;
  assign wdata_b = req.wdata;

  assign in_addr = (phase >= PH_ADDR_FIRST) && (phase <= PH_ADDR_LAST);
  assign in_read = (phase >= PH_READ_FIRST) && (phase <= PH_READ_LAST);
  assign out_sel = 2'(phase - PH_ADDR_FIRST);
  assign rd_sel  = 2'(PH_READ_LAST - phase); // phase 6 fills the MSB

  // phase counter, starts mid-frame so the first request goes out at once
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      phase <= PH_ADDR_FIRST;
    end else if (phase == PH_READ_LAST) begin
      phase <= PH_STEP;
    end else begin
      phase <= phase + 4'd1;
    end
  end

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      rd_q <= '0;
    end else if (in_read) begin
      rd_q[rd_sel] <= uio_in;
    end
  end

  assign step  = (phase == PH_STEP);
  assign rdata = rd_q;

  always_comb begin
    uo_out  = 8'h00;
    uio_out = 8'h00;
    if (arst_n && in_addr) begin // quiet while reset is held
      uo_out = addr_b[out_sel];
      if (req.write) begin
        uio_out = wdata_b[out_sel];
      end
    end else if (phase == PH_FLAG) begin
      uo_out = {7'h00, req.write};
    end
  end

  // bidirectional pins drive only on write frames
  assign uio_oe = {8{req.write}};

endmodule

`default_nettype wire

/* rtl/cpu_bus_top.sv */
/*
 * Top level. Accumulator core, its ALU and the pin bus handler,
 * wired to the 8-bit pin interface.
 */

`default_nettype none

module cpu_bus_top
  import bus_pkg::*;
  import cpu_pkg::*;
#(
  parameter logic [31:0] RESET_PC = 32'h0 // first fetch address
) (
  input  logic       clk,
  input  logic       arst_n,
  input  logic [7:0] uio_in,
  output logic [7:0] uo_out,
  output logic [7:0] uio_out,
  output logic [7:0] uio_oe
);

  bus_req_t    req;
  logic        step;
  logic [31:0] rdata;
  logic [31:0] alu_a;
  logic [31:0] alu_b;
  logic [31:0] alu_res;
  logic        alu_zero;
  alu_op_t     alu_op;

  accum_cpu #(
    .RESET_PC(RESET_PC)
  ) u_cpu (
    .clk      (clk),
    .arst_n   (arst_n),
    .step     (step),
    .rdata    (rdata),
    .alu_res  (alu_res),
    .alu_zero (alu_zero),
    .req      (req),
    .alu_a    (alu_a),
    .alu_b    (alu_b),
    .alu_op   (alu_op)
  );

  cpu_alu u_alu (
    .a    (alu_a),
    .b    (alu_b),
    .op   (alu_op),
    .res  (alu_res),
    .zero (alu_zero)
  );

  bus_phase_handler u_bus (
    .clk     (clk),
    .arst_n  (arst_n),
    .req     (req),
    .uio_in  (uio_in),
    .step    (step),
    .rdata   (rdata),
    .uo_out  (uo_out),
    .uio_out (uio_out),
    .uio_oe  (uio_oe)
  );

endmodule

`default_nettype wire

/* tests/tb_cpu_bus.sv */
/*
 * Testbench for the pin bus accumulator processor. A memory model
 * on the pins serves fetches and operands, checks each frame
 * against the bus traffic expected from small programs, and
 * watches the halt loop.
 */

`default_nettype none

module tb_cpu_bus
  import bus_pkg::*;
  import cpu_pkg::*;
();

  localparam logic [31:0] RESET_PC = 32'h100;
  localparam int CLK_HALF        = 50;
  localparam int CLK_PERIOD      = 2 * CLK_HALF;
  localparam int RESET_CYCLES    = 2;
  localparam int HALT_REPEATS    = 4;  // frames checked after HALT
  localparam int N_TESTS         = 3;
  localparam int MAX_TEST_FRAMES = 32; // longest program plus halt frames
  localparam int WATCHDOG_TIME   =
    N_TESTS * (MAX_TEST_FRAMES * FRAME_LEN + RESET_CYCLES + 2) * CLK_PERIOD
    + 20 * CLK_PERIOD;

  logic       clk = 1'b0;
  logic       arst_n;
  logic [7:0] uio_in;
  logic [7:0] uo_out;
  logic [7:0] uio_out;
  logic [7:0] uio_oe;

  cpu_bus_top #(
    .RESET_PC(RESET_PC)
  ) UUT (
    .clk     (clk),
    .arst_n  (arst_n),
    .uio_in  (uio_in),
    .uo_out  (uo_out),
    .uio_out (uio_out),
    .uio_oe  (uio_oe)
  );

  always #(CLK_HALF) clk = ~clk;

  // own phase count, restarts at phase 1 like the frame after reset
  bus_phase_t tb_phase;
  always @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      tb_phase <= PH_ADDR_FIRST;
    end else if (tb_phase == PH_READ_LAST) begin
      tb_phase <= PH_STEP;
    end else begin
      tb_phase <= tb_phase + 4'd1;
    end
  end

  logic [31:0] mem [0:1023];  // 4 KB word memory
  bus_req_t    exp_q [$];     // expected frames in order
  bus_req_t    cur;           // frame being gathered from the pins
  logic [31:0] oe_seen;       // uio_oe of phases 1-4
  logic [31:0] rword;
  logic [31:0] halt_addr;
  logic [31:0] pc_b;          // program builder state
  logic [31:0] acc_b;
  logic [31:0] rng = 32'd86;
  int          frames_seen;
  int          halt_frames;
  int          errors = 0;
  int          err_at_start;
  int          tests_run = 0;
  int          tests_failed = 0;

  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  function automatic logic [31:0] rand_word();
    rng = xorshift32(rng);
    return rng;
  endfunction

  // top nibble F for low addresses, so stray fetches act as no-operation
  function automatic logic [31:0] fill_word(input logic [31:0] addr);
    return addr ^ 32'hFC3A_5A00;
  endfunction

  function automatic bus_req_t frame_of(input logic [31:0] addr,
                                        input logic [31:0] wdata,
                                        input logic        write);
    bus_req_t f;
    f.addr  = addr;
    f.wdata = wdata;
    f.write = write;
    return f;
  endfunction

  // one word slot of 64 bytes per index, random offset inside it
  function automatic logic [31:0] data_addr(input int slot);
    logic [31:0] r;
    r = rand_word();
    return 32'h800 + (32'(slot) << 6) + {26'h0, r[5:2], 2'b00};
  endfunction

  task automatic log_failure(input string msg);
    $display("FAILED %0t: %s", $time, msg);
    errors++;
  endtask

  task automatic check_frame();
    bus_req_t want;
    if (frames_seen == 0) begin
      assert (cur.addr == RESET_PC && !cur.write && oe_seen == 32'h0)
        else log_failure($sformatf("first frame addr %h write %b, not a read at %h",
                                   cur.addr, cur.write, RESET_PC));
    end
    if (exp_q.size() > 0) begin
      want = exp_q.pop_front();
      assert (cur.addr == want.addr && cur.write == want.write)
        else log_failure($sformatf("frame %0d addr %h write %b, expected addr %h write %b",
                                   frames_seen, cur.addr, cur.write, want.addr, want.write));
      assert (!want.write || cur.wdata == want.wdata)
        else log_failure($sformatf("write to %h carries %h, expected %h",
                                   cur.addr, cur.wdata, want.wdata));
    end else begin
      assert (cur.addr == halt_addr && !cur.write)
        else log_failure($sformatf("after HALT frame addr %h write %b, expected read at %h",
                                   cur.addr, cur.write, halt_addr));
      halt_frames++;
    end
  endtask

  // memory model, one look at the pins per clock
  task automatic observe();
    logic [1:0] byte_sel;
    logic [4:0] lsb;
    if (!arst_n) begin
      assert (uo_out == 8'h00 && uio_out == 8'h00 && uio_oe == 8'h00)
        else log_failure($sformatf("pins %h/%h/%h not zero in reset", uo_out, uio_out, uio_oe));
      uio_in      = 8'h00;
      cur         = '0;
      oe_seen     = '0;
      frames_seen = 0;
      halt_frames = 0;
    end else if (tb_phase >= PH_ADDR_FIRST && tb_phase <= PH_ADDR_LAST) begin
      byte_sel              = 2'(tb_phase - PH_ADDR_FIRST);
      lsb                   = {byte_sel, 3'b000};
      cur.addr[lsb +: 8]    = uo_out; // LSB first
      cur.wdata[lsb +: 8]   = uio_out;
      oe_seen[lsb +: 8]     = uio_oe;
    end else if (tb_phase == PH_FLAG) begin
      cur.write = uo_out[0];
      assert (uo_out[7:1] == 7'h00 && uio_out == 8'h00)
        else log_failure($sformatf("phase 5 pins %h/%h", uo_out, uio_out));
      assert (oe_seen == {32{cur.write}} && uio_oe == {8{cur.write}})
        else log_failure($sformatf("uio_oe %h does not follow write flag %b",
                                   oe_seen, cur.write));
      assert (cur.write || cur.wdata == 32'h0)
        else log_failure($sformatf("uio_out carries %h on a read frame", cur.wdata));
      check_frame();
      if (cur.write) begin
        mem[cur.addr[11:2]] = cur.wdata; // commit only on flagged frames
        rword = 32'h0;
      end else begin
        rword = mem[cur.addr[11:2]];
      end
      frames_seen++;
    end else if (tb_phase >= PH_READ_FIRST && tb_phase <= PH_READ_LAST) begin
      byte_sel = 2'(PH_READ_LAST - tb_phase); // MSB in phase 6
      lsb      = {byte_sel, 3'b000};
      uio_in   = rword[lsb +: 8];
      assert (uo_out == 8'h00 && uio_out == 8'h00 && uio_oe == {8{cur.write}})
        else log_failure($sformatf("phase %0d pins %h/%h/%h", tb_phase, uo_out, uio_out, uio_oe));
    end else begin
      assert (uo_out == 8'h00 && uio_out == 8'h00 && uio_oe == {8{cur.write}})
        else log_failure($sformatf("phase 0 pins %h/%h/%h", uo_out, uio_out, uio_oe));
      uio_in  = 8'h00;
      cur     = '0;
      oe_seen = '0;
    end
  endtask

  task automatic tick();
    @(negedge clk);
    observe();
  endtask

  task automatic put_word(input logic [31:0] addr, input logic [31:0] data);
    mem[addr[11:2]] = data;
  endtask

  task automatic emit(input opcode_t op, input logic [27:0] operand);
    put_word(pc_b, {op, operand});
    exp_q.push_back(frame_of(pc_b, 32'h0, 1'b0)); // its fetch
  endtask

  task automatic prog_ldi(input logic [27:0] imm);
    emit(OP_LDI, imm);
    acc_b = {4'h0, imm};
    pc_b  = pc_b + 32'd4;
  endtask

  task automatic prog_st(input logic [31:0] addr);
    emit(OP_ST, addr[27:0]);
    exp_q.push_back(frame_of(addr, acc_b, 1'b1));
    pc_b = pc_b + 32'd4;
  endtask

  task automatic prog_mem_op(input opcode_t op, input logic [31:0] addr,
                             input logic [31:0] value);
    put_word(addr, value);
    emit(op, addr[27:0]);
    exp_q.push_back(frame_of(addr, 32'h0, 1'b0));
    case (op)
      OP_ADD:  acc_b = acc_b + value;
      OP_SUB:  acc_b = acc_b - value;
      OP_AND:  acc_b = acc_b & value;
      OP_OR:   acc_b = acc_b | value;
      OP_XOR:  acc_b = acc_b ^ value;
      default: acc_b = value; // LD
    endcase
    pc_b = pc_b + 32'd4;
  endtask

  task automatic prog_jmp(input logic [31:0] target);
    emit(OP_JMP, target[27:0]);
    pc_b = target;
  endtask

  task automatic prog_jz(input logic [31:0] target);
    emit(OP_JZ, target[27:0]);
    pc_b = (acc_b == 32'h0) ? target : pc_b + 32'd4;
  endtask

  task automatic prog_halt();
    emit(OP_HALT, 28'h0);
    halt_addr = pc_b;
  endtask

  // reset asserted, memory refilled, builder cleared
  task automatic start_test();
    @(negedge clk);
    arst_n = 1'b0;
    err_at_start = errors;
    tick();
    for (int i = 0; i < 1024; i++) begin
      mem[10'(i)] = fill_word(32'(i) << 2);
    end
    exp_q.delete();
    pc_b      = RESET_PC;
    acc_b     = 32'h0;
    halt_addr = RESET_PC;
  endtask

  task automatic finish_test(input string name);
    int budget;
    budget = exp_q.size() + HALT_REPEATS + 4;
    repeat (RESET_CYCLES - 1) tick();
    arst_n = 1'b1;
    #(CLK_HALF / 2); // phase 1 lasts half a clock after release
    observe();
    while (halt_frames < HALT_REPEATS && frames_seen < budget) begin
      tick();
    end
    if (halt_frames < HALT_REPEATS) begin
      $display("test %s: program never settled in its HALT loop within %0d frames",
               name, budget);
      errors++;
    end
    tests_run++;
    if (errors == err_at_start) begin
      $display("test %s: ok, %0d frames", name, frames_seen);
    end else begin
      $display("test %s: %0d errors", name, errors - err_at_start);
      tests_failed++;
    end
  endtask

  initial begin : run_tests
    logic [31:0] r;
    arst_n = 1'b1;
    uio_in = 8'h00;

    start_test();
    for (int i = 0; i < 4; i++) begin
      r = rand_word();
      prog_ldi(r[27:0]);
      prog_st(data_addr(i));
    end
    prog_halt();
    finish_test("ldi_st");

    start_test();
    prog_mem_op(OP_LD, data_addr(0), rand_word());
    prog_mem_op(OP_ADD, data_addr(1), rand_word());
    prog_mem_op(OP_SUB, data_addr(2), rand_word());
    prog_mem_op(OP_AND, data_addr(3), rand_word());
    prog_mem_op(OP_OR, data_addr(4), rand_word());
    prog_mem_op(OP_XOR, data_addr(5), rand_word());
    prog_st(data_addr(6));
    prog_halt();
    finish_test("alu_chain");

    start_test();
    prog_ldi(28'h0);
    r = rand_word();
    prog_jz(32'h200 + {26'h0, r[5:2], 2'b00}); // taken
    r = rand_word();
    prog_ldi(r[27:0] | 28'h1);
    prog_jz(32'h280);                         // falls through
    r = rand_word();
    prog_jmp(32'h300 + {26'h0, r[5:2], 2'b00});
    prog_st(data_addr(0));
    prog_halt();
    finish_test("branches");

    $display("summary: %0d tests, %0d failed, %0d errors", tests_run, tests_failed, errors);
    if (errors == 0) begin
      $display(">>> PASS");
    end else begin
      $display(">>> FAIL");
    end
    $finish;
  end

  initial begin
    #(WATCHDOG_TIME);
    $display("watchdog: tests still running after %0d time units", WATCHDOG_TIME);
    $display(">>> FAIL");
    $finish;
  end

endmodule

`default_nettype wire

/* list.f */
rtl/bus_pkg.sv
rtl/cpu_pkg.sv
rtl/cpu_alu.sv
rtl/accum_cpu.sv
rtl/bus_phase_handler.sv
rtl/cpu_bus_top.sv
tests/tb_cpu_bus.sv

/* run.sh */
#!/bin/sh
# build with Verilator, run, and judge the result from the log
cd "$(dirname "$0")" || exit 1
verilator --binary --assert --top-module tb_cpu_bus -f list.f -o tb_cpu_bus \
  && ./obj_dir/tb_cpu_bus > sim.log 2>&1 \
  || { echo "build or simulation error"; cat sim.log 2>/dev/null; exit 1; }
cat sim.log
grep -q '>>> FAIL' sim.log && { echo "simulation reported failure"; exit 1; }
grep -q '>>> PASS' sim.log || { echo "no pass message in log"; exit 1; }
echo "simulation passed"
